// File: common/radio_params.svh
// Settings addresses, readback codes and reset values of the radio core
// The time block uses three consecutive addresses starting at RADIO_SR_TIME
`ifndef RADIO_PARAMS_SVH
`define RADIO_PARAMS_SVH

////////////////////
// Settings-bus register addresses
`define RADIO_SR_DACSYNC    8'd5
`define RADIO_SR_LOOPBACK   8'd6
`define RADIO_SR_TEST       8'd7
`define RADIO_SR_MISC_OUTS  8'd24
`define RADIO_SR_READBACK   8'd32
// High word, then low word, then control
`define RADIO_SR_TIME       8'd128
`define RADIO_SR_CODEC_IDLE 8'd250

// Time control bits
`define RADIO_TIME_NOW_BIT  0
`define RADIO_TIME_PPS_BIT  1

////////////////////
// Readback select codes, 0 and 7 read zero
`define RADIO_RB_TIME       3'd1
`define RADIO_RB_LASTPPS    3'd2
`define RADIO_RB_RX_TEST    3'd3
`define RADIO_RB_MISC       3'd4
`define RADIO_RB_CODEC      3'd5
`define RADIO_RB_RADIO_NUM  3'd6

`define RADIO_MISC_OUTS_RESET 32'h0000_0000

`endif

// File: common/radio_pkg.sv
// Shared types for the radio-clock settings side
// Codec words carry I in the upper half and Q in the lower half
`default_nettype none

package radio_pkg;

   ////////////////////
   // Bus and register words
   ////////////////////

   // Register or port word
   typedef logic [31:0] word_t;

   // Settings-bus address
   typedef logic [7:0] set_addr_t;

   ////////////////////
   // Time and samples
   ////////////////////

   // Radio time in clock ticks
   typedef logic [63:0] vita_time_t;

   // One 16-bit converter sample
   typedef logic signed [15:0] sample_t;

   // Codec word, I first so it lands in the upper half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_word_t;

   ////////////////////
   // Readback
   ////////////////////

   typedef logic [2:0]  rb_addr_t;
   typedef logic [63:0] rb_data_t;

endpackage : radio_pkg

`default_nettype wire

// File: logic/radio_settings.sv
// Control register bank on the settings bus, no handshake
// A register shows its new value the cycle after the write
// Any write to the DAC-sync address gives a one-cycle o_sync_dacs pulse
`timescale 1ns/1ns
`default_nettype none
`include "radio_params.svh"

module radio_settings (
   input  wire logic                 i_radio_clk,
   input  wire logic                 i_rst,

   input  wire logic                 i_set_stb,
   input  wire radio_pkg::set_addr_t i_set_addr,
   input  wire radio_pkg::word_t     i_set_data,

   output logic                      o_loopback,
   output radio_pkg::word_t          o_test_word,
   output radio_pkg::rb_addr_t       o_rb_addr,
   output radio_pkg::word_t          o_misc_outs,
   output radio_pkg::iq_word_t       o_codec_idle,
   output logic                      o_sync_dacs
);

   ////////////////////
   // Address decode
   ////////////////////

   logic wr_dacsync;
   logic wr_loopback;
   logic wr_test;
   logic wr_misc_outs;
   logic wr_readback;
   logic wr_codec_idle;

   assign wr_dacsync    = i_set_stb && (i_set_addr == `RADIO_SR_DACSYNC);
   assign wr_loopback   = i_set_stb && (i_set_addr == `RADIO_SR_LOOPBACK);
   assign wr_test       = i_set_stb && (i_set_addr == `RADIO_SR_TEST);
   assign wr_misc_outs  = i_set_stb && (i_set_addr == `RADIO_SR_MISC_OUTS);
   assign wr_readback   = i_set_stb && (i_set_addr == `RADIO_SR_READBACK);
   assign wr_codec_idle = i_set_stb && (i_set_addr == `RADIO_SR_CODEC_IDLE);

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         o_loopback   <= 1'b0;
         o_test_word  <= '0;
         o_rb_addr    <= '0;
         o_misc_outs  <= `RADIO_MISC_OUTS_RESET;
         o_codec_idle <= '0;
         o_sync_dacs  <= 1'b0;
      end else begin
         // Loop TX back into the RX frontend
         if (wr_loopback) begin
            o_loopback <= i_set_data[0];
         end

         // Scratch value shown on the readback mux
         if (wr_test) begin
            o_test_word <= i_set_data;
         end

         if (wr_readback) begin
            o_rb_addr <= i_set_data[2:0];
         end

         if (wr_misc_outs) begin
            o_misc_outs <= i_set_data;
         end

         // Word sent to the DAC while TX is not running
         if (wr_codec_idle) begin
            o_codec_idle <= i_set_data;
         end

         // Data is ignored, only the write itself counts
         o_sync_dacs <= wr_dacsync;
      end
   end

endmodule : radio_settings

`default_nettype wire

// File: timekeeper/timekeeper.sv
// 64-bit radio time, loaded at once or at the next synchronized PPS rise
// A load-now takes effect one edge after the control write
// i_pps is asynchronous and passes two flops before edge detection
`timescale 1ns/1ns
`default_nettype none
`include "radio_params.svh"

module timekeeper (
   input  wire logic                 i_radio_clk,
   input  wire logic                 i_rst,
   input  wire logic                 i_pps,

   input  wire logic                 i_set_stb,
   input  wire radio_pkg::set_addr_t i_set_addr,
   input  wire radio_pkg::word_t     i_set_data,

   output radio_pkg::vita_time_t     o_vita_time,
   output radio_pkg::vita_time_t     o_vita_time_lastpps
);

   import radio_pkg::*;

   localparam set_addr_t ADDR_HI   = `RADIO_SR_TIME;
   localparam set_addr_t ADDR_LO   = `RADIO_SR_TIME + 8'd1;
   localparam set_addr_t ADDR_CTRL = `RADIO_SR_TIME + 8'd2;

   word_t      pending_hi;
   word_t      pending_lo;
   vita_time_t pending_time;
   logic       wr_ctrl;
   logic       load_now;
   logic       pps_armed;
   logic [1:0] pps_sync;
   logic       pps_last;
   logic       pps_edge;

   assign pending_time = {pending_hi, pending_lo};
   assign wr_ctrl      = i_set_stb && (i_set_addr == ADDR_CTRL);
   assign pps_edge     = pps_sync[1] & ~pps_last;

   // Pending time, held until a load
   always_ff @(posedge i_radio_clk) begin
      if (i_set_stb && (i_set_addr == ADDR_HI)) begin
         pending_hi <= i_set_data;
      end
      if (i_set_stb && (i_set_addr == ADDR_LO)) begin
         pending_lo <= i_set_data;
      end
   end

   ////////////////////
   // PPS sync and load requests
   ////////////////////

   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         pps_sync  <= '0;
         pps_last  <= 1'b0;
         load_now  <= 1'b0;
         pps_armed <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], i_pps};
         pps_last <= pps_sync[1];
         load_now <= wr_ctrl && i_set_data[`RADIO_TIME_NOW_BIT];
         // A new arm wins over the clear from a coincident edge
         if (wr_ctrl && i_set_data[`RADIO_TIME_PPS_BIT]) begin
            pps_armed <= 1'b1;
         end else if (pps_edge) begin
            pps_armed <= 1'b0;
         end
      end
   end

   ////////////////////
   // Time counter and last-PPS capture
   ////////////////////

   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         o_vita_time         <= '0;
         o_vita_time_lastpps <= '0;
      end else begin
         if (load_now || (pps_edge && pps_armed)) begin
            o_vita_time <= pending_time;
         end else begin
            o_vita_time <= o_vita_time + 64'd1;
         end
         if (pps_edge) begin
            o_vita_time_lastpps <= pps_armed ? pending_time : o_vita_time;
         end
      end
   end

endmodule : timekeeper

`default_nettype wire

// File: logic/radio_codec_io.sv
// DAC word select and RX frontend input select, one register each
// Loopback takes the registered DAC word, so RX lags TX by one cycle
`timescale 1ns/1ns
`default_nettype none

module radio_codec_io (
   input  wire logic                i_radio_clk,
   input  wire logic                i_rst,

   input  wire logic                i_tx_run,
   input  wire radio_pkg::iq_word_t i_tx_sample,
   input  wire radio_pkg::iq_word_t i_codec_idle,

   input  wire logic                i_loopback,
   input  wire radio_pkg::iq_word_t i_rx,

   output radio_pkg::iq_word_t      o_tx,
   output radio_pkg::iq_word_t      o_rx_fe
);

   ////////////////////
   // TX side
   ////////////////////

   // Idle word whenever the transmitter is stopped
   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         o_tx <= '0;
      end else begin
         o_tx <= i_tx_run ? i_tx_sample : i_codec_idle;
      end
   end

   ////////////////////
   // RX side
   ////////////////////

   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         o_rx_fe <= '0;
      end else begin
         o_rx_fe <= i_loopback ? o_tx : i_rx;
      end
   end

endmodule : radio_codec_io

`default_nettype wire

// File: logic/radio_readback.sv
// Registered readback mux with one cycle from select or data to o_readback
// Codes 0 and 7 read zero
`timescale 1ns/1ns
`default_nettype none
`include "radio_params.svh"

module radio_readback #(
   parameter int RADIO_NUM = 0
) (
   input  wire logic                  i_radio_clk,
   input  wire logic                  i_rst,

   input  wire radio_pkg::rb_addr_t   i_rb_addr,
   input  wire radio_pkg::vita_time_t i_vita_time,
   input  wire radio_pkg::vita_time_t i_vita_time_lastpps,
   input  wire radio_pkg::word_t      i_test_word,
   input  wire radio_pkg::word_t      i_misc_ins,
   input  wire radio_pkg::iq_word_t   i_rx,
   input  wire radio_pkg::iq_word_t   i_tx,

   output radio_pkg::rb_data_t        o_readback
);

   import radio_pkg::*;

   rb_data_t rb_next;

   // Upper word first in every pair
   always_comb begin
      case (i_rb_addr)
         `RADIO_RB_TIME:      rb_next = i_vita_time;
         `RADIO_RB_LASTPPS:   rb_next = i_vita_time_lastpps;
         `RADIO_RB_RX_TEST:   rb_next = {i_rx, i_test_word};
         `RADIO_RB_MISC:      rb_next = {i_misc_ins, 32'h0};
         `RADIO_RB_CODEC:     rb_next = {i_tx, i_rx};
         // Zero-extended, so a negative number reads as its 32-bit pattern
         `RADIO_RB_RADIO_NUM: rb_next = {32'h0, 32'(RADIO_NUM)};
         default:             rb_next = '0;
      endcase
   end

   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         o_readback <= '0;
      end else begin
         o_readback <= rb_next;
      end
   end

endmodule : radio_readback

`default_nettype wire

// File: logic/radio_core.sv
// Radio-clock settings side: control registers, timekeeper, codec I/O, readback
// Single clock, settings writes take effect on the strobe edge, no back-pressure
`timescale 1ns/1ns
`default_nettype none

module radio_core #(
   parameter int RADIO_NUM = 0
) (
   input  wire logic                 i_radio_clk,
   input  wire logic                 i_rst,

   input  wire logic                 i_set_stb,
   input  wire radio_pkg::set_addr_t i_set_addr,
   input  wire radio_pkg::word_t     i_set_data,

   input  wire logic                 i_pps,
   input  wire logic                 i_tx_run,
   input  wire radio_pkg::iq_word_t  i_tx_sample,
   input  wire radio_pkg::iq_word_t  i_rx,
   input  wire radio_pkg::word_t     i_misc_ins,

   output radio_pkg::iq_word_t       o_tx,
   output radio_pkg::iq_word_t       o_rx_fe,
   output radio_pkg::word_t          o_misc_outs,
   output logic                      o_sync_dacs,
   output radio_pkg::rb_data_t       o_readback
);

   import radio_pkg::*;

   logic       loopback;
   word_t      test_word;
   rb_addr_t   rb_addr;
   iq_word_t   codec_idle;
   vita_time_t vita_time;
   vita_time_t vita_time_lastpps;

   ////////////////////
   // Settings and time
   ////////////////////

   radio_settings u_radio_settings (
      .i_radio_clk  (i_radio_clk),
      .i_rst        (i_rst),
      .i_set_stb    (i_set_stb),
      .i_set_addr   (i_set_addr),
      .i_set_data   (i_set_data),
      .o_loopback   (loopback),
      .o_test_word  (test_word),
      .o_rb_addr    (rb_addr),
      .o_misc_outs  (o_misc_outs),
      .o_codec_idle (codec_idle),
      .o_sync_dacs  (o_sync_dacs)
   );

   timekeeper u_timekeeper (
      .i_radio_clk         (i_radio_clk),
      .i_rst               (i_rst),
      .i_pps               (i_pps),
      .i_set_stb           (i_set_stb),
      .i_set_addr          (i_set_addr),
      .i_set_data          (i_set_data),
      .o_vita_time         (vita_time),
      .o_vita_time_lastpps (vita_time_lastpps)
   );

   ////////////////////
   // Codec paths and readback
   ////////////////////

   radio_codec_io u_radio_codec_io (
      .i_radio_clk  (i_radio_clk),
      .i_rst        (i_rst),
      .i_tx_run     (i_tx_run),
      .i_tx_sample  (i_tx_sample),
      .i_codec_idle (codec_idle),
      .i_loopback   (loopback),
      .i_rx         (i_rx),
      .o_tx         (o_tx),
      .o_rx_fe      (o_rx_fe)
   );

   // Readback sees the raw ADC word, not the looped-back one
   radio_readback #(.RADIO_NUM(RADIO_NUM)) u_radio_readback (
      .i_radio_clk         (i_radio_clk),
      .i_rst               (i_rst),
      .i_rb_addr           (rb_addr),
      .i_vita_time         (vita_time),
      .i_vita_time_lastpps (vita_time_lastpps),
      .i_test_word         (test_word),
      .i_misc_ins          (i_misc_ins),
      .i_rx                (i_rx),
      .i_tx                (o_tx),
      .o_readback          (o_readback)
   );

endmodule : radio_core

`default_nettype wire

// File: testbench/tb_radio_core.sv
// Table-driven testbench for radio_core with RADIO_NUM set to 3
// Each entry writes the readback select, then its own settings write, then checks
// Time readback is only predictable in the entry that performs a load-now
`timescale 1ns/1ns
`default_nettype none
`include "radio_params.svh"

module tb_radio_core;

   import radio_pkg::*;

   localparam int TB_RADIO_NUM   = 3;
   localparam int NUM_TESTS      = 21;
   localparam int TIMEOUT_CYCLES = 20 * NUM_TESTS + 100;
   // Control write edge, load edge, then one more count before the readback register
   localparam vita_time_t LOAD_TO_CHECK = 64'd1;
   localparam set_addr_t ADDR_UNUSED = 8'd99;

   logic clk = 1'b0;
   logic rst;
   logic set_stb;
   set_addr_t set_addr;
   word_t set_data;
   logic pps;
   logic tx_run;
   iq_word_t tx_sample;
   iq_word_t rx;
   word_t misc_ins;
   iq_word_t o_tx;
   iq_word_t o_rx_fe;
   word_t o_misc_outs;
   logic o_sync_dacs;
   rb_data_t o_readback;

   // Stimulus and expected values, one slot per test
   string      name_tab [NUM_TESTS];
   set_addr_t  addr_tab [NUM_TESTS];
   word_t      data_tab [NUM_TESTS];
   rb_addr_t   rb_tab [NUM_TESTS];
   logic       pps_tab [NUM_TESTS];
   logic       run_tab [NUM_TESTS];
   iq_word_t   sample_tab [NUM_TESTS];
   iq_word_t   rx_tab [NUM_TESTS];
   word_t      misc_tab [NUM_TESTS];
   rb_data_t   exp_rb_tab [NUM_TESTS];
   iq_word_t   exp_tx_tab [NUM_TESTS];
   iq_word_t   exp_rx_fe_tab [NUM_TESTS];
   word_t      exp_misc_tab [NUM_TESTS];
   logic       exp_sync_tab [NUM_TESTS];

   // Reference state of the register bank
   logic     m_loopback = 1'b0;
   word_t    m_test = '0;
   rb_addr_t m_rb = '0;
   word_t    m_misc_outs = '0;
   iq_word_t m_idle = '0;
   word_t    m_pend_hi = '0;
   word_t    m_pend_lo = '0;

   word_t rng_state = 32'd96032;
   int    n_tests = 0;
   int    error_count = 0;
   int    tests_passed = 0;
   int    tests_failed = 0;
   int    cycle_count = 0;

   radio_core #(.RADIO_NUM(TB_RADIO_NUM)) i_radio_core (
      .i_radio_clk (clk),
      .i_rst       (rst),
      .i_set_stb   (set_stb),
      .i_set_addr  (set_addr),
      .i_set_data  (set_data),
      .i_pps       (pps),
      .i_tx_run    (tx_run),
      .i_tx_sample (tx_sample),
      .i_rx        (rx),
      .i_misc_ins  (misc_ins),
      .o_tx        (o_tx),
      .o_rx_fe     (o_rx_fe),
      .o_misc_outs (o_misc_outs),
      .o_sync_dacs (o_sync_dacs),
      .o_readback  (o_readback)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the test table did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   ////////////////////
   // Random data and compare tasks
   ////////////////////

   function automatic word_t xorshift32(input word_t x);
      word_t y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic word_t next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic check_rb(input string name, input rb_data_t exp, input rb_data_t act);
      if (exp !== act) begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_iq(input string name, input iq_word_t exp, input iq_word_t act);
      if (exp !== act) begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
         error_count++;
      end
   endtask

   ////////////////////
   // Table build, expectations follow the register rules in order
   ////////////////////

   task automatic add_entry(input string name, input set_addr_t addr, input word_t data,
                            input rb_addr_t rb, input logic pps_lvl, input logic run,
                            input iq_word_t sample, input iq_word_t rx_in, input word_t misc);
      iq_word_t tx_next;
      rb_data_t rb_next;
      name_tab[n_tests] = name;
      addr_tab[n_tests] = addr;
      data_tab[n_tests] = data;
      rb_tab[n_tests] = rb;
      pps_tab[n_tests] = pps_lvl;
      run_tab[n_tests] = run;
      sample_tab[n_tests] = sample;
      rx_tab[n_tests] = rx_in;
      misc_tab[n_tests] = misc;
      // Select write comes first, the entry's own write second
      m_rb = rb;
      case (addr)
         `RADIO_SR_LOOPBACK:        m_loopback = data[0];
         `RADIO_SR_TEST:            m_test = data;
         `RADIO_SR_MISC_OUTS:       m_misc_outs = data;
         `RADIO_SR_READBACK:        m_rb = data[2:0];
         `RADIO_SR_CODEC_IDLE:      m_idle = data;
         `RADIO_SR_TIME:            m_pend_hi = data;
         `RADIO_SR_TIME + 8'd1:     m_pend_lo = data;
         default: ;
      endcase
      tx_next = run ? sample : m_idle;
      case (m_rb)
         `RADIO_RB_TIME:      rb_next = {m_pend_hi, m_pend_lo} + LOAD_TO_CHECK;
         `RADIO_RB_LASTPPS:   rb_next = {m_pend_hi, m_pend_lo};
         `RADIO_RB_RX_TEST:   rb_next = {rx_in, m_test};
         `RADIO_RB_MISC:      rb_next = {misc, 32'h0};
         `RADIO_RB_CODEC:     rb_next = {tx_next, rx_in};
         `RADIO_RB_RADIO_NUM: rb_next = 64'(TB_RADIO_NUM);
         default:             rb_next = '0;
      endcase
      exp_rb_tab[n_tests] = rb_next;
      exp_tx_tab[n_tests] = tx_next;
      exp_rx_fe_tab[n_tests] = m_loopback ? tx_next : rx_in;
      exp_misc_tab[n_tests] = m_misc_outs;
      exp_sync_tab[n_tests] = (addr == `RADIO_SR_DACSYNC);
      n_tests++;
   endtask

   task automatic build_table();
      word_t r;
      add_entry("after_reset", ADDR_UNUSED, next_random(), 3'd0, 0, 0, next_random(), '0,
                next_random());
      add_entry("test_reg", `RADIO_SR_TEST, next_random(), `RADIO_RB_RX_TEST, 0, 0,
                next_random(), next_random(), next_random());
      add_entry("misc_outs", `RADIO_SR_MISC_OUTS, next_random(), `RADIO_RB_MISC, 0, 0,
                next_random(), next_random(), next_random());
      r = next_random();
      add_entry("rb_select", `RADIO_SR_READBACK, {r[31:3], `RADIO_RB_CODEC}, 3'd0, 0, 0,
                next_random(), next_random(), next_random());
      add_entry("radio_num", ADDR_UNUSED, next_random(), `RADIO_RB_RADIO_NUM, 0, 0,
                next_random(), next_random(), next_random());
      add_entry("code7_zero", ADDR_UNUSED, next_random(), 3'd7, 0, 0, next_random(),
                next_random(), next_random());
      add_entry("code0_zero", ADDR_UNUSED, next_random(), 3'd0, 0, 0, next_random(),
                next_random(), next_random());
      add_entry("unused_addr", 8'd200, next_random(), `RADIO_RB_RX_TEST, 0, 0, next_random(),
                next_random(), next_random());
      add_entry("dac_sync", `RADIO_SR_DACSYNC, next_random(), `RADIO_RB_CODEC, 0, 0,
                next_random(), next_random(), next_random());
      add_entry("codec_idle", `RADIO_SR_CODEC_IDLE, next_random(), `RADIO_RB_CODEC, 0, 0,
                next_random(), next_random(), next_random());
      add_entry("tx_run", ADDR_UNUSED, next_random(), `RADIO_RB_CODEC, 0, 1, next_random(),
                next_random(), next_random());
      add_entry("loopback_on", `RADIO_SR_LOOPBACK, 32'd1, `RADIO_RB_CODEC, 0, 1,
                next_random(), next_random(), next_random());
      add_entry("loopback_idle", ADDR_UNUSED, next_random(), `RADIO_RB_CODEC, 0, 0,
                next_random(), next_random(), next_random());
      add_entry("loopback_off", `RADIO_SR_LOOPBACK, 32'd0, `RADIO_RB_CODEC, 0, 1,
                next_random(), next_random(), next_random());
      add_entry("time_hi", `RADIO_SR_TIME, next_random(), 3'd0, 0, 0, '0, '0, '0);
      add_entry("time_lo", `RADIO_SR_TIME + 8'd1, next_random(), 3'd0, 0, 0, '0, '0, '0);
      add_entry("time_now", `RADIO_SR_TIME + 8'd2, (32'd1 << `RADIO_TIME_NOW_BIT),
                `RADIO_RB_TIME, 0, 0, '0, '0, '0);
      add_entry("pps_hi", `RADIO_SR_TIME, next_random(), 3'd0, 0, 0, '0, '0, '0);
      add_entry("pps_lo", `RADIO_SR_TIME + 8'd1, next_random(), 3'd0, 0, 0, '0, '0, '0);
      add_entry("pps_arm", `RADIO_SR_TIME + 8'd2, (32'd1 << `RADIO_TIME_PPS_BIT), 3'd0,
                0, 0, '0, '0, '0);
      // i_pps rises here and stays high to the end
      add_entry("pps_edge", ADDR_UNUSED, next_random(), `RADIO_RB_LASTPPS, 1, 0, '0, '0, '0);
   endtask

   ////////////////////
   // Apply one entry and check it
   ////////////////////

   task automatic run_entry(input int k);
      int errors_before;
      errors_before = error_count;
      @(negedge clk);
      set_stb = 1'b1;
      set_addr = `RADIO_SR_READBACK;
      set_data = {29'd0, rb_tab[k]};
      pps = pps_tab[k];
      tx_run = run_tab[k];
      tx_sample = sample_tab[k];
      rx = rx_tab[k];
      misc_ins = misc_tab[k];
      @(negedge clk);
      set_addr = addr_tab[k];
      set_data = data_tab[k];
      @(negedge clk);
      set_stb = 1'b0;
      check_bit({name_tab[k], " o_sync_dacs"}, exp_sync_tab[k], o_sync_dacs);
      repeat (3) begin
         @(negedge clk);
         check_bit({name_tab[k], " o_sync_dacs after pulse"}, 1'b0, o_sync_dacs);
      end
      check_rb({name_tab[k], " o_readback"}, exp_rb_tab[k], o_readback);
      check_iq({name_tab[k], " o_tx"}, exp_tx_tab[k], o_tx);
      check_iq({name_tab[k], " o_rx_fe"}, exp_rx_fe_tab[k], o_rx_fe);
      check_word({name_tab[k], " o_misc_outs"}, exp_misc_tab[k], o_misc_outs);
      if (error_count == errors_before) begin
         tests_passed++;
         $display("test %0d %s: ok", k, name_tab[k]);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d mismatches", k, name_tab[k], error_count - errors_before);
      end
   endtask

   initial begin
      rst = 1'b1;
      set_stb = 1'b0;
      set_addr = '0;
      set_data = '0;
      pps = 1'b0;
      tx_run = 1'b0;
      tx_sample = '0;
      rx = '0;
      misc_ins = '0;
      build_table();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_iq("reset o_tx", '0, o_tx);
      check_iq("reset o_rx_fe", '0, o_rx_fe);
      check_word("reset o_misc_outs", '0, o_misc_outs);
      check_rb("reset o_readback", '0, o_readback);
      check_bit("reset o_sync_dacs", 1'b0, o_sync_dacs);
      $display("reset values: %0d mismatches", error_count);
      for (int k = 0; k < n_tests; k++) begin
         run_entry(k);
      end
      $display("%0d tests, %0d passed, %0d failed, %0d mismatches in total",
               n_tests, tests_passed, tests_failed, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule : tb_radio_core

`default_nettype wire

// File: radio_core.f
+incdir+common
common/radio_pkg.sv
logic/radio_settings.sv
timekeeper/timekeeper.sv
logic/radio_codec_io.sv
logic/radio_readback.sv
logic/radio_core.sv
testbench/tb_radio_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the radio_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   --top-module tb_radio_core \
   -f radio_core.f \
   --Mdir obj_dir \
   -o tb_radio_core

./obj_dir/tb_radio_core > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "Simulation failed"
   exit 1
fi

echo "Simulation passed"
